//--- Bender.yml
package:
  name: dram_scheduler

sources:
  - hdl/dram_sched_pkg.sv
  - hdl/request_intake.sv
  - hdl/bank_queue.sv
  - hdl/bank_state_regs.sv
  - hdl/command_picker.sv
  - hdl/dram_scheduler.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_dram_scheduler.sv

//--- dram_scheduler.f
+incdir+tests
hdl/dram_sched_pkg.sv
hdl/request_intake.sv
hdl/bank_queue.sv
hdl/bank_state_regs.sv
hdl/command_picker.sv
hdl/dram_scheduler.sv
tests/tb_dram_scheduler.sv

//--- hdl/bank_queue.sv
`timescale 1ns/1ps

module bank_queue import dram_sched_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 push,
    input  logic [row_bits-1:0]  in_row,
    input  logic [col_bits-1:0]  in_col,
    input  logic                 in_write,
    input  logic [data_bits-1:0] in_data,
    input  logic                 pop,
    output logic                 empty,
    output logic                 full,
    output logic [row_bits-1:0]  head_row,
    output logic [col_bits-1:0]  head_col,
    output logic                 head_write,
    output logic [data_bits-1:0] head_data
);

    localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_bits = $clog2(queue_depth + 1);

    logic [row_bits-1:0]  row_mem   [queue_depth];
    logic [col_bits-1:0]  col_mem   [queue_depth];
    logic                 write_mem [queue_depth];
    logic [data_bits-1:0] data_mem  [queue_depth];

    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign empty   = (count == '0);
    assign full    = (count == count_bits'(queue_depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            row_mem[wr_ptr]   <= in_row;
            col_mem[wr_ptr]   <= in_col;
            write_mem[wr_ptr] <= in_write;
            data_mem[wr_ptr]  <= in_data;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head is the oldest entry, valid when not empty
    assign head_row   = row_mem[rd_ptr];
    assign head_col   = col_mem[rd_ptr];
    assign head_write = write_mem[rd_ptr];
    assign head_data  = data_mem[rd_ptr];

endmodule

//--- hdl/bank_state_regs.sv
`timescale 1ns/1ps

module bank_state_regs import dram_sched_pkg::*; #(
    parameter int act_latency = 8,
    parameter int pre_latency = 5
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 issue,
    input  cmd_kind_t            issue_kind,
    input  logic [bank_bits-1:0] issue_bank,
    input  logic [row_bits-1:0]  issue_row,
    output logic [num_banks-1:0] open,
    output logic [row_bits-1:0]  open_row [num_banks],
    output logic [num_banks-1:0] busy
);

    localparam int max_latency = (act_latency > pre_latency) ? act_latency : pre_latency;
    localparam int cnt_bits    = $clog2(max_latency + 1);

    logic [cnt_bits-1:0] busy_cnt [num_banks];

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        logic hit;

        assign hit     = issue && (issue_bank == bank_bits'(b));
        assign busy[b] = (busy_cnt[b] != '0);

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                open[b]     <= 1'b0;
                busy_cnt[b] <= '0;
            end else begin
                if (hit && issue_kind == cmd_activate) begin
                    open[b]     <= 1'b1;
                    busy_cnt[b] <= cnt_bits'(act_latency);
                end else if (hit && issue_kind == cmd_precharge) begin
                    open[b]     <= 1'b0;
                    busy_cnt[b] <= cnt_bits'(pre_latency);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;  // row timing in progress
                end
            end
        end

        // only looked at while the bank is open
        always_ff @(posedge clk_in) begin
            if (hit && issue_kind == cmd_activate) begin
                open_row[b] <= issue_row;
            end
        end
    end

endmodule

//--- hdl/command_picker.sv
`timescale 1ns/1ps

module command_picker import dram_sched_pkg::*; #(
    parameter int col_gap = 4
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic [num_banks-1:0] empty,
    input  logic [row_bits-1:0]  head_row   [num_banks],
    input  logic [col_bits-1:0]  head_col   [num_banks],
    input  logic                 head_write [num_banks],
    input  logic [data_bits-1:0] head_data  [num_banks],
    input  logic [num_banks-1:0] open,
    input  logic [row_bits-1:0]  open_row   [num_banks],
    input  logic [num_banks-1:0] busy,
    output logic [num_banks-1:0] pop,
    output logic                 issue,
    output cmd_kind_t            issue_kind,
    output logic [bank_bits-1:0] issue_bank,
    output logic [row_bits-1:0]  issue_row,
    output logic                 cmd_req,
    output cmd_kind_t            cmd_kind,
    output cmd_addr_u            cmd_addr,
    output logic [data_bits-1:0] cmd_data,
    input  logic                 cmd_ack
);

    localparam int gap_bits = $clog2(col_gap + 1);

    logic [bank_bits-1:0] last_bank;   // bank served most recently
    logic [gap_bits-1:0]  gap_cnt;
    logic                 gap_ok;
    logic                 choose_en;
    logic                 found;
    logic [bank_bits-1:0] sel;
    cmd_kind_t            sel_kind;
    logic                 sel_col;
    cmd_addr_u            next_addr;

    assign gap_ok    = (gap_cnt == '0);
    assign choose_en = !cmd_req && !cmd_ack; // previous handshake fully closed
    assign sel_col   = (sel_kind == cmd_read) || (sel_kind == cmd_write);

    // round robin search starting after last_bank
    always_comb begin
        logic [bank_bits-1:0] idx;
        logic                 row_hit;
        found    = 1'b0;
        sel      = '0;
        sel_kind = cmd_read;
        for (int k = 0; k < num_banks; k++) begin
            idx     = last_bank + bank_bits'(k + 1);
            row_hit = open[idx] && (head_row[idx] == open_row[idx]);
            if (!found && !empty[idx] && !busy[idx]) begin
                if (row_hit) begin
                    if (gap_ok) begin
                        found    = 1'b1;
                        sel      = idx;
                        sel_kind = head_write[idx] ? cmd_write : cmd_read;
                    end
                end else if (open[idx]) begin
                    // closing a row also waits out the column gap so a write can land
                    if (gap_ok) begin
                        found    = 1'b1;
                        sel      = idx;
                        sel_kind = cmd_precharge;
                    end
                end else begin
                    found    = 1'b1;
                    sel      = idx;
                    sel_kind = cmd_activate;
                end
            end
        end
    end

    always_comb begin
        next_addr = '0;
        if (sel_kind == cmd_activate) begin
            next_addr.row_view.bank = sel;
            next_addr.row_view.row  = head_row[sel];
        end else begin
            next_addr.col_view.bank = sel;
            next_addr.col_view.col  = (sel_kind == cmd_precharge) ? '0 : head_col[sel];
        end
    end

    assign issue      = choose_en && found;
    assign issue_kind = sel_kind;
    assign issue_bank = sel;
    assign issue_row  = head_row[sel];

    always_comb begin
        pop = '0;
        if (issue && sel_col) begin
            pop[sel] = 1'b1;           // read or write retires the head
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_req   <= 1'b0;
            last_bank <= '1;           // first search starts at bank 0
            gap_cnt   <= '0;
        end else begin
            if (cmd_req) begin
                if (cmd_ack) begin
                    cmd_req <= 1'b0;
                end
            end else if (issue) begin
                cmd_req   <= 1'b1;
                last_bank <= sel;
            end
            if (issue && sel_col) begin
                gap_cnt <= gap_bits'(col_gap - 1);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    // command fields hold until the next issue
    always_ff @(posedge clk_in) begin
        if (issue) begin
            cmd_kind <= sel_kind;
            cmd_addr <= next_addr;
            cmd_data <= (sel_kind == cmd_write) ? head_data[sel] : '0;
        end
    end

endmodule

//--- hdl/dram_sched_pkg.sv
package dram_sched_pkg;

    // bank index is {bank group, bank in group}
    localparam int bank_group_bits    = 1;
    localparam int bank_in_group_bits = 2;
    localparam int bank_bits          = bank_group_bits + bank_in_group_bits;
    localparam int num_banks          = 1 << bank_bits;

    localparam int row_bits   = 8;
    localparam int col_bits   = 4;
    localparam int paddr_bits = row_bits + bank_bits + col_bits; // row | group | bank | col

    localparam int data_bits = 32; // write data per command

    // command address word and the zero padding of each view
    localparam int cmd_addr_bits = 16;
    localparam int row_pad_bits  = cmd_addr_bits - bank_bits - row_bits;
    localparam int col_pad_bits  = cmd_addr_bits - bank_bits - col_bits;

    typedef enum logic [1:0] {
        cmd_read      = 2'd0,
        cmd_write     = 2'd1,
        cmd_activate  = 2'd2,
        cmd_precharge = 2'd3
    } cmd_kind_t;

    // activate carries a row, the other commands carry a column
    typedef union packed {
        struct packed {
            logic [bank_bits-1:0]    bank;
            logic [row_pad_bits-1:0] pad;
            logic [row_bits-1:0]     row;
        } row_view;
        struct packed {
            logic [bank_bits-1:0]    bank;
            logic [col_pad_bits-1:0] pad;
            logic [col_bits-1:0]     col;  // zero on precharge
        } col_view;
    } cmd_addr_u;

endpackage

//--- hdl/dram_scheduler.sv
`timescale 1ns/1ps

module dram_scheduler import dram_sched_pkg::*; #(
    parameter int queue_depth = 4,
    parameter int act_latency = 8,
    parameter int pre_latency = 5,
    parameter int col_gap     = 4
) (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  req,
    input  logic [paddr_bits-1:0] addr,
    input  logic                  write,
    input  logic [data_bits-1:0]  wdata,
    output logic                  ack,
    output logic                  cmd_req,
    input  logic                  cmd_ack,
    output cmd_kind_t             cmd_kind,
    output cmd_addr_u             cmd_addr,
    output logic [data_bits-1:0]  cmd_data
);

    // intake to queues
    logic                 push;
    logic [bank_bits-1:0] push_bank;
    logic [row_bits-1:0]  push_row;
    logic [col_bits-1:0]  push_col;
    logic                 push_write;
    logic [data_bits-1:0] push_data;

    // queues to picker
    logic [num_banks-1:0] q_empty;
    logic [num_banks-1:0] q_full;
    logic [num_banks-1:0] q_pop;
    logic [row_bits-1:0]  head_row   [num_banks];
    logic [col_bits-1:0]  head_col   [num_banks];
    logic                 head_write [num_banks];
    logic [data_bits-1:0] head_data  [num_banks];

    // picker and bank state
    logic                 issue;
    cmd_kind_t            issue_kind;
    logic [bank_bits-1:0] issue_bank;
    logic [row_bits-1:0]  issue_row;
    logic [num_banks-1:0] bank_open;
    logic [row_bits-1:0]  bank_open_row [num_banks];
    logic [num_banks-1:0] bank_busy;

    request_intake request_intake_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .req        (req),
        .addr       (addr),
        .write      (write),
        .wdata      (wdata),
        .ack        (ack),
        .full       (q_full),
        .push       (push),
        .push_bank  (push_bank),
        .push_row   (push_row),
        .push_col   (push_col),
        .push_write (push_write),
        .push_data  (push_data)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_queue
        bank_queue #(
            .queue_depth (queue_depth)
        ) bank_queue_i (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .push       (push && (push_bank == bank_bits'(b))),
            .in_row     (push_row),
            .in_col     (push_col),
            .in_write   (push_write),
            .in_data    (push_data),
            .pop        (q_pop[b]),
            .empty      (q_empty[b]),
            .full       (q_full[b]),
            .head_row   (head_row[b]),
            .head_col   (head_col[b]),
            .head_write (head_write[b]),
            .head_data  (head_data[b])
        );
    end

    bank_state_regs #(
        .act_latency (act_latency),
        .pre_latency (pre_latency)
    ) bank_state_regs_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .issue      (issue),
        .issue_kind (issue_kind),
        .issue_bank (issue_bank),
        .issue_row  (issue_row),
        .open       (bank_open),
        .open_row   (bank_open_row),
        .busy       (bank_busy)
    );

    command_picker #(
        .col_gap (col_gap)
    ) command_picker_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .empty      (q_empty),
        .head_row   (head_row),
        .head_col   (head_col),
        .head_write (head_write),
        .head_data  (head_data),
        .open       (bank_open),
        .open_row   (bank_open_row),
        .busy       (bank_busy),
        .pop        (q_pop),
        .issue      (issue),
        .issue_kind (issue_kind),
        .issue_bank (issue_bank),
        .issue_row  (issue_row),
        .cmd_req    (cmd_req),
        .cmd_kind   (cmd_kind),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack)
    );

endmodule

//--- hdl/request_intake.sv
`timescale 1ns/1ps

module request_intake import dram_sched_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 req,
    input  logic [paddr_bits-1:0] addr,
    input  logic                 write,
    input  logic [data_bits-1:0] wdata,
    output logic                 ack,
    input  logic [num_banks-1:0] full,
    output logic                 push,
    output logic [bank_bits-1:0] push_bank,
    output logic [row_bits-1:0]  push_row,
    output logic [col_bits-1:0]  push_col,
    output logic                 push_write,
    output logic [data_bits-1:0] push_data
);

    // field positions inside the physical address
    localparam int bank_lsb  = col_bits;
    localparam int group_lsb = col_bits + bank_in_group_bits;
    localparam int row_lsb   = col_bits + bank_bits;

    logic [bank_group_bits-1:0]    bank_group;
    logic [bank_in_group_bits-1:0] bank_in_group;

    assign bank_group    = addr[group_lsb +: bank_group_bits];
    assign bank_in_group = addr[bank_lsb +: bank_in_group_bits];

    assign push_bank  = {bank_group, bank_in_group};
    assign push_row   = addr[row_lsb +: row_bits];
    assign push_col   = addr[0 +: col_bits];
    assign push_write = write;
    assign push_data  = wdata;

    // one push per handshake, held off while the target queue is full
    assign push = req && !ack && !full[push_bank];

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            ack <= 1'b0;
        end else begin
            if (push) begin
                ack <= 1'b1;            // entry is in the queue
            end else if (ack && !req) begin
                ack <= 1'b0;            // host has released req
            end
        end
    end

endmodule

//--- tests/tb_dram_scheduler_tasks.svh
// physical address layout is row | group | bank | col
function automatic logic [paddr_bits-1:0] make_addr(input logic [row_bits-1:0] row,
                                                    input logic [bank_bits-1:0] bank,
                                                    input logic [col_bits-1:0] col);
    return {row, bank, col};
endfunction

function automatic cmd_addr_u row_word(input logic [bank_bits-1:0] bank,
                                       input logic [row_bits-1:0] row);
    cmd_addr_u w;
    w = '0;
    w.row_view.bank = bank;
    w.row_view.row  = row;
    return w;
endfunction

function automatic cmd_addr_u col_word(input logic [bank_bits-1:0] bank,
                                       input logic [col_bits-1:0] col);
    cmd_addr_u w;
    w = '0;
    w.col_view.bank = bank;
    w.col_view.col  = col;
    return w;
endfunction

function automatic bit is_column(input cmd_kind_t kind);
    return (kind == cmd_read) || (kind == cmd_write);
endfunction

function automatic int count_columns();
    int n;
    n = 0;
    foreach (log_kind[i]) begin
        if (is_column(log_kind[i])) begin
            n++;
        end
    end
    return n;
endfunction

task automatic fail_check(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
endtask

task automatic check_kind(input string name, input cmd_kind_t exp, input cmd_kind_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("Mismatch at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
    end
endtask

task automatic check_addr(input string name, input cmd_addr_u exp, input cmd_addr_u act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_data(input string name, input logic [data_bits-1:0] exp,
                          input logic [data_bits-1:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_command(input int idx, input cmd_kind_t kind, input cmd_addr_u word);
    check_kind($sformatf("cmd_kind[%0d]", idx), kind, log_kind[idx]);
    check_addr($sformatf("cmd_addr[%0d]", idx), word, log_addr[idx]);
endtask

task automatic check_spacing(input string what, input int first, input int second,
                             input int min_gap);
    if (log_cycle[second] - log_cycle[first] < min_gap) begin
        fail_check($sformatf("%s only %0d cycles apart, need %0d", what,
                             log_cycle[second] - log_cycle[first], min_gap));
    end
endtask

// request port, host side
task automatic start_request(input logic [paddr_bits-1:0] a, input logic w,
                             input logic [data_bits-1:0] d);
    @(negedge clk_in);
    while (ack) @(negedge clk_in);
    addr  = a;
    write = w;
    wdata = d;
    req   = 1'b1;
endtask

task automatic wait_ack();
    do @(negedge clk_in); while (!ack);
endtask

task automatic end_request();
    req = 1'b0;
    do @(negedge clk_in); while (ack);
endtask

task automatic send_request(input logic [paddr_bits-1:0] a, input logic w,
                            input logic [data_bits-1:0] d);
    start_request(a, w, d);
    wait_ack();
    end_request();
endtask

task automatic wait_log(input int n);
    while (log_kind.size() < n) @(negedge clk_in);
    repeat (20) @(negedge clk_in);  // nothing further may follow
    if (log_kind.size() != n) begin
        fail_check($sformatf("expected %0d commands, saw %0d", n, log_kind.size()));
    end
endtask

//--- tests/tb_dram_scheduler.sv
`timescale 1ns/1ps

module tb_dram_scheduler import dram_sched_pkg::*; ();

    localparam int queue_depth    = 4;
    localparam int act_latency    = 8;
    localparam int pre_latency    = 5;
    localparam int col_gap        = 4;
    localparam int random_count   = 24;
    // budget per test, doubled
    localparam int timeout_cycles = 2 * (100 + 150 + 250 + 1200 + 300);

    logic                  clk_in;
    logic                  rst_in;
    logic                  req;
    logic [paddr_bits-1:0] addr;
    logic                  write;
    logic [data_bits-1:0]  wdata;
    logic                  ack;
    logic                  cmd_req;
    logic                  cmd_ack = 1'b0;
    cmd_kind_t             cmd_kind;
    cmd_addr_u             cmd_addr;
    logic [data_bits-1:0]  cmd_data;

    int          cycle;
    int          checks;
    int          errors;
    int          tests_run;
    int          ack_delay;
    int          wait_cnt;
    bit          hold_ack;
    bit          seen;

    // command log written by the controller model
    cmd_kind_t            log_kind  [$];
    cmd_addr_u            log_addr  [$];
    logic [data_bits-1:0] log_data  [$];
    int                   log_cycle [$];

    `include "tb_dram_scheduler_tasks.svh"

    dram_scheduler #(
        .queue_depth (queue_depth),
        .act_latency (act_latency),
        .pre_latency (pre_latency),
        .col_gap     (col_gap)
    ) dram_scheduler_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req      (req),
        .addr     (addr),
        .write    (write),
        .wdata    (wdata),
        .ack      (ack),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .cmd_kind (cmd_kind),
        .cmd_addr (cmd_addr),
        .cmd_data (cmd_data)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle++;
        if (cycle >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // controller model, logs each command and holds cmd_ack off for ack_delay cycles
    always @(negedge clk_in) begin
        if (rst_in) begin
            cmd_ack = 1'b0;
            seen    = 1'b0;
        end else if (cmd_req && !cmd_ack) begin
            if (!seen) begin
                seen     = 1'b1;
                wait_cnt = 0;
                log_kind.push_back(cmd_kind);
                log_addr.push_back(cmd_addr);
                log_data.push_back(cmd_data);
                log_cycle.push_back(cycle);
            end else begin
                check_kind("cmd_kind (held)", log_kind[$], cmd_kind);
                check_addr("cmd_addr (held)", log_addr[$], cmd_addr);
                check_data("cmd_data (held)", log_data[$], cmd_data);
            end
            if (!hold_ack && wait_cnt >= ack_delay) begin
                cmd_ack = 1'b1;
            end else begin
                wait_cnt++;
            end
        end else if (!cmd_req) begin
            cmd_ack = 1'b0;  // handshake closed
            seen    = 1'b0;
        end
    end

    task automatic apply_reset();
        @(negedge clk_in);
        rst_in = 1'b1;
        repeat (8) @(negedge clk_in);
        rst_in = 1'b0;
        log_kind.delete();
        log_addr.delete();
        log_data.delete();
        log_cycle.delete();
    endtask

    task automatic wait_idle();
        repeat (2) @(negedge clk_in);
        while (cmd_req || cmd_ack) @(negedge clk_in);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_idle();
        int errors_before;
        errors_before = errors;
        apply_reset();
        if (ack !== 1'b0) begin
            fail_check("ack is not low after reset");
        end
        if (cmd_req !== 1'b0) begin
            fail_check("cmd_req is not low after reset");
        end
        repeat (20) @(negedge clk_in);
        if (log_kind.size() != 0) begin
            fail_check("command issued with no request pending");
        end
        report_test("idle after reset", errors_before);
    endtask

    task automatic test_closed_read();
        int                   errors_before;
        logic [row_bits-1:0]  row;
        logic [col_bits-1:0]  col;
        logic [bank_bits-1:0] bank;
        errors_before = errors;
        apply_reset();
        bank = bank_bits'(2);
        row  = row_bits'($urandom);
        col  = col_bits'($urandom);
        send_request(make_addr(row, bank, col), 1'b0, '0);
        wait_log(2);
        check_command(0, cmd_activate, row_word(bank, row));
        check_command(1, cmd_read, col_word(bank, col));
        check_spacing("activate to read", 0, 1, act_latency);
        report_test("closed bank read", errors_before);
    endtask

    task automatic test_row_conflict();
        int                   errors_before;
        logic [row_bits-1:0]  row_a;
        logic [row_bits-1:0]  row_b;
        logic [col_bits-1:0]  col_a;
        logic [col_bits-1:0]  col_b;
        logic [data_bits-1:0] data;
        logic [bank_bits-1:0] bank;
        errors_before = errors;
        apply_reset();
        bank  = bank_bits'(5);
        row_a = row_bits'($urandom);
        row_b = ~row_a;                 // always a different row
        col_a = col_bits'($urandom);
        col_b = col_bits'($urandom);
        data  = $urandom;
        send_request(make_addr(row_a, bank, col_a), 1'b1, data);
        send_request(make_addr(row_b, bank, col_b), 1'b0, '0);
        wait_log(5);
        check_command(0, cmd_activate, row_word(bank, row_a));
        check_command(1, cmd_write, col_word(bank, col_a));
        check_data("cmd_data[1]", data, log_data[1]);
        check_command(2, cmd_precharge, col_word(bank, '0));
        check_command(3, cmd_activate, row_word(bank, row_b));
        check_command(4, cmd_read, col_word(bank, col_b));
        check_spacing("write to precharge", 1, 2, col_gap);
        check_spacing("precharge to activate", 2, 3, pre_latency);
        check_spacing("activate to read", 3, 4, act_latency);
        report_test("row conflict", errors_before);
    endtask

    task automatic test_random_mix();
        int                    errors_before;
        int                    last_col;
        int                    hit;
        logic [paddr_bits-1:0] a;
        logic                  w;
        logic [data_bits-1:0]  d;
        logic [bank_bits-1:0]  b;
        logic [bank_bits-1:0]  exp_bank [$];
        cmd_kind_t             exp_kind [$];
        cmd_addr_u             exp_word [$];
        logic [data_bits-1:0]  exp_data [$];
        errors_before = errors;
        apply_reset();
        ack_delay = 1;
        for (int i = 0; i < random_count; i++) begin
            a = paddr_bits'($urandom);
            a[paddr_bits-1 -: row_bits] = row_bits'($urandom % 2); // two rows, so row hits pile up
            w = 1'($urandom);
            d = $urandom;
            b = a[col_bits +: bank_bits];
            exp_bank.push_back(b);
            exp_kind.push_back(w ? cmd_write : cmd_read);
            exp_word.push_back(col_word(b, a[col_bits-1:0]));
            exp_data.push_back(d);
            send_request(a, w, d);
        end
        while (count_columns() < random_count) @(negedge clk_in);
        wait_idle();
        last_col = -1;
        for (int i = 0; i < log_kind.size(); i++) begin
            if (is_column(log_kind[i])) begin
                if (last_col >= 0) begin
                    check_spacing("column commands", last_col, i, col_gap);
                end
                last_col = i;
                b        = log_addr[i].col_view.bank;
                hit      = -1;
                for (int j = exp_bank.size() - 1; j >= 0; j--) begin
                    if (exp_bank[j] == b) begin
                        hit = j;    // oldest pending request of that bank
                    end
                end
                if (hit < 0) begin
                    fail_check($sformatf("column command to bank %0d without a request", b));
                end else begin
                    check_kind("cmd_kind", exp_kind[hit], log_kind[i]);
                    check_addr("cmd_addr", exp_word[hit], log_addr[i]);
                    if (exp_kind[hit] == cmd_write) begin
                        check_data("cmd_data", exp_data[hit], log_data[i]);
                    end
                    exp_bank.delete(hit);
                    exp_kind.delete(hit);
                    exp_word.delete(hit);
                    exp_data.delete(hit);
                end
            end
        end
        if (exp_bank.size() != 0) begin
            fail_check($sformatf("%0d requests never produced a command", exp_bank.size()));
        end
        ack_delay = 0;
        report_test("random mix", errors_before);
    endtask

    task automatic test_back_pressure();
        int                   errors_before;
        logic [row_bits-1:0]  row;
        logic [bank_bits-1:0] bank;
        logic [data_bits-1:0] data [queue_depth + 1];
        errors_before = errors;
        apply_reset();
        bank      = bank_bits'(6);
        row       = row_bits'($urandom);
        ack_delay = 7;
        hold_ack  = 1'b1;               // first activate stays unacknowledged
        for (int i = 0; i <= queue_depth; i++) begin
            data[i] = $urandom;
        end
        for (int i = 0; i < queue_depth; i++) begin
            send_request(make_addr(row, bank, col_bits'(i)), 1'b1, data[i]);
        end
        start_request(make_addr(row, bank, col_bits'(queue_depth)), 1'b1, data[queue_depth]);
        repeat (10) @(negedge clk_in);
        if (ack) begin
            fail_check("ack rose while the bank queue was full");
        end
        if (count_columns() != 0) begin
            fail_check("column command issued while the activate was unacknowledged");
        end
        hold_ack = 1'b0;
        wait_ack();
        if (count_columns() == 0) begin
            fail_check("ack rose before a column command freed a queue slot");
        end
        end_request();
        wait_log(queue_depth + 2);
        check_command(0, cmd_activate, row_word(bank, row));
        for (int i = 0; i <= queue_depth; i++) begin
            check_command(i + 1, cmd_write, col_word(bank, col_bits'(i)));
            check_data($sformatf("cmd_data[%0d]", i + 1), data[i], log_data[i + 1]);
        end
        ack_delay = 0;
        report_test("back pressure", errors_before);
    endtask

    initial begin
        clk_in    = 1'b0;
        rst_in    = 1'b1;
        req       = 1'b0;
        addr      = '0;
        write     = 1'b0;
        wdata     = '0;
        hold_ack  = 1'b0;
        ack_delay = 0;
        void'($urandom(32'h7e9fc91f));
        test_idle();
        test_closed_read();
        wait_idle();
        test_row_conflict();
        wait_idle();
        test_random_mix();
        wait_idle();
        test_back_pressure();
        wait_idle();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
